// ==== compile.f ====
logic/isa_pkg.sv
logic/bus_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/issue_ctrl.sv
logic/retire_counter.sv
logic/host_port.sv
logic/dual_exec_top.sv
tests/tb_dual_exec.sv

// ==== logic/alu.sv ====
`default_nettype none

module alu (
	input wire isa_pkg::pipe_slot_t slot,
	input wire [31:0] opnd_a,
	input wire [31:0] opnd_b,
	output logic [31:0] result
);

	logic [31:0] imm_ext;
	logic [31:0] opnd_2;

	always_comb begin
		if (slot.op == isa_pkg::OP_ADDI) begin
			imm_ext = {{(32 - isa_pkg::IMM_W){slot.imm[isa_pkg::IMM_W-1]}}, slot.imm};
		end else begin
			imm_ext = {{(32 - isa_pkg::IMM_W){1'b0}}, slot.imm}; // Logical ops zero-extend.
		end
	end

	assign opnd_2 = slot.op[3] ? imm_ext : opnd_b;

	always_comb begin
		if (!slot.valid) begin
			result = '0;
		end else begin
			case (slot.op)
				isa_pkg::OP_ADD, isa_pkg::OP_ADDI: result = opnd_a + opnd_2;
				isa_pkg::OP_SUB: result = opnd_a - opnd_2;
				isa_pkg::OP_AND, isa_pkg::OP_ANDI: result = opnd_a & opnd_2;
				isa_pkg::OP_OR, isa_pkg::OP_ORI: result = opnd_a | opnd_2;
				isa_pkg::OP_XOR, isa_pkg::OP_XORI: result = opnd_a ^ opnd_2;
				isa_pkg::OP_SLL: result = opnd_a << opnd_2[4:0];
				isa_pkg::OP_SRL: result = opnd_a >> opnd_2[4:0];
				default: result = '0; // NOP and unused codes.
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	// Byte addresses of the host register map.
	localparam logic [7:0] ADR_INSTR_A  = 8'h00;
	localparam logic [7:0] ADR_INSTR_B  = 8'h04;
	localparam logic [7:0] ADR_STATUS   = 8'h08;
	localparam logic [7:0] ADR_RETIRED  = 8'h0c;
	localparam logic [7:0] ADR_SPLITS   = 8'h10;
	localparam logic [7:0] ADR_GPR_BASE = 8'h80;

	// Wishbone classic request, single transfers only.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [7:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// ==== logic/dual_exec_top.sv ====
`default_nettype none

module dual_exec_top (
	input wire clk,
	input wire rst,
	input wire bus_pkg::wb_req_t req,
	output bus_pkg::wb_rsp_t rsp
);

	logic busy;
	logic start;
	logic split;
	isa_pkg::instr_u instr_a;
	isa_pkg::instr_u instr_b;
	logic [isa_pkg::REG_ADDR_W-1:0] host_raddr;
	logic [isa_pkg::REG_ADDR_W-1:0] raddr_1a;
	logic [isa_pkg::REG_ADDR_W-1:0] raddr_1b;
	logic [isa_pkg::REG_ADDR_W-1:0] raddr_2a;
	logic [isa_pkg::REG_ADDR_W-1:0] raddr_2b;
	logic [31:0] rdata_1a;
	logic [31:0] rdata_1b;
	logic [31:0] rdata_2a;
	logic [31:0] rdata_2b;
	isa_pkg::pipe_slot_t slot_a;
	isa_pkg::pipe_slot_t slot_b;
	logic [31:0] result_a;
	logic [31:0] result_b;
	isa_pkg::wb_slot_t wb_a;
	isa_pkg::wb_slot_t wb_b;
	logic [31:0] retired;
	logic [31:0] splits;

	host_port i_host_port (
		.clk, .rst, .req, .rsp, .busy, .start, .instr_a, .instr_b, .host_raddr,
		.gpr_rdata(rdata_1a), .retired, .splits
	);

	issue_ctrl i_issue_ctrl (
		.clk, .rst, .start, .instr_a, .instr_b, .host_raddr, .busy, .split,
		.raddr_1a, .raddr_1b, .raddr_2a, .raddr_2b, .slot_a, .slot_b,
		.result_a, .result_b, .wb_a, .wb_b
	);

	retire_counter i_retire_counter (.clk, .rst, .wb_a, .wb_b, .split, .retired, .splits);

	reg_file i_reg_file (
		.clk, .rst, .raddr_1a, .raddr_1b, .raddr_2a, .raddr_2b,
		.rdata_1a, .rdata_1b, .rdata_2a, .rdata_2b, .wb_a, .wb_b
	);

	alu i_alu_a (.slot(slot_a), .opnd_a(rdata_1a), .opnd_b(rdata_1b), .result(result_a));
	alu i_alu_b (.slot(slot_b), .opnd_a(rdata_2a), .opnd_b(rdata_2b), .result(result_b));

endmodule

`default_nettype wire

// ==== logic/host_port.sv ====
`default_nettype none

module host_port (
	input wire clk,
	input wire rst,
	input wire bus_pkg::wb_req_t req,
	output bus_pkg::wb_rsp_t rsp,
	input wire busy,
	output logic start,
	output isa_pkg::instr_u instr_a,
	output isa_pkg::instr_u instr_b,
	output logic [isa_pkg::REG_ADDR_W-1:0] host_raddr,
	input wire [31:0] gpr_rdata,
	input wire [31:0] retired,
	input wire [31:0] splits
);

	logic active;
	logic is_gpr;
	logic wr_instr_a;
	logic wr_instr_b;
	logic must_wait;
	logic accept;
	logic ack_q;
	logic [31:0] rdata_mux;
	logic [31:0] dat_q;

	assign active = req.cyc && req.stb && !ack_q; // Skip the cycle we ack in.
	assign is_gpr = req.adr >= bus_pkg::ADR_GPR_BASE;
	assign wr_instr_a = req.we && req.adr == bus_pkg::ADR_INSTR_A;
	assign wr_instr_b = req.we && req.adr == bus_pkg::ADR_INSTR_B;
	assign must_wait = wr_instr_b || (!req.we && is_gpr);
	assign accept = active && !(must_wait && busy);
	assign host_raddr = req.adr[6:2];

	always_comb begin
		if (req.we) begin
			rdata_mux = '0;
		end else if (is_gpr) begin
			rdata_mux = gpr_rdata;
		end else begin
			case (req.adr)
				bus_pkg::ADR_STATUS: rdata_mux = {31'b0, busy};
				bus_pkg::ADR_RETIRED: rdata_mux = retired;
				bus_pkg::ADR_SPLITS: rdata_mux = splits;
				default: rdata_mux = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			start <= 1'b0;
		end else begin
			ack_q <= accept;
			start <= accept && wr_instr_b; // Lines up with the ack.
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dat_q <= rdata_mux;
			if (wr_instr_a) begin
				instr_a <= req.dat;
			end
			if (wr_instr_b) begin
				instr_b <= req.dat;
			end
		end
	end

	assign rsp = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	localparam int REG_COUNT  = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W      = 18;

	// Bit 3 set marks the immediate form.
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SLL  = 4'h6,
		OP_SRL  = 4'h7,
		OP_ADDI = 4'h8,
		OP_ANDI = 4'h9,
		OP_ORI  = 4'ha,
		OP_XORI = 4'hb
	} alu_op_e;

	typedef struct packed {
		alu_op_e op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [12:0] unused;
	} r_fmt_t;

	typedef struct packed {
		alu_op_e op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [IMM_W-1:0] imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

	typedef struct packed {
		logic valid;
		alu_op_e op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [IMM_W-1:0] imm;
	} pipe_slot_t;

	typedef struct packed {
		logic wen;
		logic [REG_ADDR_W-1:0] waddr;
		logic [31:0] wdata;
	} wb_slot_t;

endpackage

`default_nettype wire

// ==== logic/issue_ctrl.sv ====
`default_nettype none

module issue_ctrl (
	input wire clk,
	input wire rst,
	input wire start,
	input wire isa_pkg::instr_u instr_a,
	input wire isa_pkg::instr_u instr_b,
	input wire [isa_pkg::REG_ADDR_W-1:0] host_raddr,
	output logic busy,
	output logic split,
	output logic [isa_pkg::REG_ADDR_W-1:0] raddr_1a,
	output logic [isa_pkg::REG_ADDR_W-1:0] raddr_1b,
	output logic [isa_pkg::REG_ADDR_W-1:0] raddr_2a,
	output logic [isa_pkg::REG_ADDR_W-1:0] raddr_2b,
	output isa_pkg::pipe_slot_t slot_a,
	output isa_pkg::pipe_slot_t slot_b,
	input wire [31:0] result_a,
	input wire [31:0] result_b,
	output isa_pkg::wb_slot_t wb_a,
	output isa_pkg::wb_slot_t wb_b
);

	typedef enum logic [2:0] {IDLE, ISSUE_PAIR, ISSUE_A, ISSUE_B, DRAIN} state_e;

	state_e state;
	state_e state_next;
	isa_pkg::pipe_slot_t dec_a;
	isa_pkg::pipe_slot_t dec_b;
	isa_pkg::pipe_slot_t held_a;
	isa_pkg::pipe_slot_t held_b;
	logic dependent;

	// Immediate form has no rs2, so that port reads register 0.
	function automatic isa_pkg::pipe_slot_t decode(input isa_pkg::instr_u word);
		isa_pkg::pipe_slot_t s;
		s.valid = 1'b1;
		s.op = word.r.op;
		s.rd = word.r.rd;
		s.rs1 = word.r.rs1;
		s.rs2 = word.r.op[3] ? '0 : word.r.rs2;
		s.imm = word.i.imm;
		return s;
	endfunction

	always_comb begin
		dec_a = decode(instr_a);
		dec_b = decode(instr_b);
		dependent = dec_a.op != isa_pkg::OP_NOP && dec_a.rd != '0 &&
			dec_b.op != isa_pkg::OP_NOP &&
			(dec_b.rs1 == dec_a.rd || dec_b.rs2 == dec_a.rd);
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: if (start) state_next = dependent ? ISSUE_A : ISSUE_PAIR;
			ISSUE_PAIR: state_next = DRAIN;
			ISSUE_A: state_next = ISSUE_B;
			ISSUE_B: state_next = DRAIN;
			DRAIN: state_next = IDLE; // Last write commits here.
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (start && state == IDLE) begin
			held_a <= dec_a;
			held_b <= dec_b;
		end
	end

	always_comb begin
		slot_a = held_a;
		slot_b = held_b;
		slot_a.valid = state == ISSUE_PAIR || state == ISSUE_A;
		slot_b.valid = state == ISSUE_PAIR || state == ISSUE_B;
	end

	assign busy = state != IDLE;
	assign split = state == ISSUE_A;

	assign raddr_1a = busy ? held_a.rs1 : host_raddr; // Host reads use the idle port.
	assign raddr_1b = held_a.rs2;
	assign raddr_2a = held_b.rs1;
	assign raddr_2b = held_b.rs2;

	always_ff @(posedge clk) begin
		wb_a.waddr <= slot_a.rd;
		wb_a.wdata <= result_a;
		wb_b.waddr <= slot_b.rd;
		wb_b.wdata <= result_b;
		if (rst) begin
			wb_a.wen <= 1'b0;
			wb_b.wen <= 1'b0;
		end else begin
			wb_a.wen <= slot_a.valid && slot_a.op != isa_pkg::OP_NOP;
			wb_b.wen <= slot_b.valid && slot_b.op != isa_pkg::OP_NOP;
		end
	end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none

module reg_file (
	input wire clk,
	input wire rst,
	input wire [isa_pkg::REG_ADDR_W-1:0] raddr_1a,
	input wire [isa_pkg::REG_ADDR_W-1:0] raddr_1b,
	input wire [isa_pkg::REG_ADDR_W-1:0] raddr_2a,
	input wire [isa_pkg::REG_ADDR_W-1:0] raddr_2b,
	output logic [31:0] rdata_1a,
	output logic [31:0] rdata_1b,
	output logic [31:0] rdata_2a,
	output logic [31:0] rdata_2b,
	input wire isa_pkg::wb_slot_t wb_a,
	input wire isa_pkg::wb_slot_t wb_b
);

	logic [31:0] regs [isa_pkg::REG_COUNT];
	logic b_overrides_a;

	// Pipe b data ahead of pipe a data ahead of the array.
	function automatic logic [31:0] read_port(
		input logic [isa_pkg::REG_ADDR_W-1:0] addr,
		input logic [31:0] stored,
		input isa_pkg::wb_slot_t wa,
		input isa_pkg::wb_slot_t wb
	);
		if (addr == '0)
			return '0;
		if (wb.wen && wb.waddr == addr)
			return wb.wdata;
		if (wa.wen && wa.waddr == addr)
			return wa.wdata;
		return stored;
	endfunction

	assign rdata_1a = read_port(raddr_1a, regs[raddr_1a], wb_a, wb_b);
	assign rdata_1b = read_port(raddr_1b, regs[raddr_1b], wb_a, wb_b);
	assign rdata_2a = read_port(raddr_2a, regs[raddr_2a], wb_a, wb_b);
	assign rdata_2b = read_port(raddr_2b, regs[raddr_2b], wb_a, wb_b);

	assign b_overrides_a = wb_b.wen && wb_b.waddr == wb_a.waddr; // Slave pipe wins.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < isa_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wb_a.wen && wb_a.waddr != '0 && !b_overrides_a) begin
				regs[wb_a.waddr] <= wb_a.wdata;
			end
			if (wb_b.wen && wb_b.waddr != '0) begin
				regs[wb_b.waddr] <= wb_b.wdata;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/retire_counter.sv ====
`default_nettype none

module retire_counter (
	input wire clk,
	input wire rst,
	input wire isa_pkg::wb_slot_t wb_a,
	input wire isa_pkg::wb_slot_t wb_b,
	input wire split,
	output logic [31:0] retired,
	output logic [31:0] splits
);

	logic [31:0] retire_inc;

	assign retire_inc = 32'(wb_a.wen) + 32'(wb_b.wen); // Zero, one or two.

	always_ff @(posedge clk) begin
		if (rst) begin
			retired <= '0;
			splits <= '0;
		end else begin
			retired <= retired + retire_inc;
			if (split) begin
				splits <= splits + 32'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_dual_exec.sv ====
`default_nettype none

module tb_dual_exec;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ACK_TIMEOUT = 50;

	logic clk;
	logic rst;
	bus_pkg::wb_req_t req;
	bus_pkg::wb_rsp_t rsp;

	logic [31:0] model_regs [32];
	int unsigned model_retired;
	int unsigned model_splits;
	logic [31:0] lcg_state;
	int errors;
	int timeouts;

	dual_exec_top i_dual_exec_top (.clk, .rst, .req, .rsp);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [31:0] encode_r(input isa_pkg::alu_op_e op, input int rd,
			input int rs1, input int rs2);
		isa_pkg::r_fmt_t f;
		f.op = op;
		f.rd = 5'(rd);
		f.rs1 = 5'(rs1);
		f.rs2 = 5'(rs2);
		f.unused = '0;
		return f;
	endfunction

	function automatic logic [31:0] encode_i(input isa_pkg::alu_op_e op, input int rd,
			input int rs1, input logic [31:0] imm);
		isa_pkg::i_fmt_t f;
		f.op = op;
		f.rd = 5'(rd);
		f.rs1 = 5'(rs1);
		f.imm = 18'(imm);
		return f;
	endfunction

	// Reference ALU. ADDI sign-extends, logical immediates zero-extend.
	function automatic logic [31:0] expected_result(input isa_pkg::instr_u w,
			input logic [31:0] x, input logic [31:0] y);
		logic [31:0] sext;
		logic [31:0] zext;
		logic [31:0] res;
		sext = {{14{w.i.imm[17]}}, w.i.imm};
		zext = {14'b0, w.i.imm};
		case (w.r.op)
			isa_pkg::OP_ADD: res = x + y;
			isa_pkg::OP_SUB: res = x - y;
			isa_pkg::OP_AND: res = x & y;
			isa_pkg::OP_OR: res = x | y;
			isa_pkg::OP_XOR: res = x ^ y;
			isa_pkg::OP_SLL: res = x << y[4:0];
			isa_pkg::OP_SRL: res = x >> y[4:0];
			isa_pkg::OP_ADDI: res = x + sext;
			isa_pkg::OP_ANDI: res = x & zext;
			isa_pkg::OP_ORI: res = x | zext;
			isa_pkg::OP_XORI: res = x ^ zext;
			default: res = '0;
		endcase
		return res;
	endfunction

	function automatic void write_model(input logic [4:0] addr, input logic [31:0] val);
		if (addr != 5'd0)
			model_regs[addr] = val;
	endfunction

	// Dependent pairs run in order, others read old values and b wins.
	function automatic void apply_pair(input isa_pkg::instr_u a, input isa_pkg::instr_u b);
		logic [31:0] res_a;
		logic [31:0] res_b;
		logic dependent;
		dependent = a.r.rd != 5'd0 &&
			(b.r.rs1 == a.r.rd || (!b.r.op[3] && b.r.rs2 == a.r.rd));
		res_a = expected_result(a, model_regs[a.r.rs1], model_regs[a.r.rs2]);
		if (dependent) begin
			write_model(a.r.rd, res_a);
			model_splits++;
		end
		res_b = expected_result(b, model_regs[b.r.rs1], model_regs[b.r.rs2]);
		if (!dependent)
			write_model(a.r.rd, res_a);
		write_model(b.r.rd, res_b);
		if (a.r.op != isa_pkg::OP_NOP)
			model_retired++;
		if (b.r.op != isa_pkg::OP_NOP)
			model_retired++;
	endfunction

	task automatic bus_transfer(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat, output int cycles);
		bit done;
		done = 1'b0;
		cycles = 0;
		rdat = '0;
		@(posedge clk);
		req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		while (!done && cycles < ACK_TIMEOUT) begin
			@(negedge clk); // Ack is stable here.
			cycles++;
			if (rsp.ack) begin
				done = 1'b1;
				rdat = rsp.dat;
			end
		end
		if (!done) begin
			timeouts++;
			$display("Timeout: no ack for address %h after %0d cycles", adr, cycles);
		end
		@(posedge clk);
		req <= '0;
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		int cycles;
		bus_transfer(1'b1, adr, wdat, unused, cycles);
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [31:0] rdat);
		int cycles;
		bus_transfer(1'b0, adr, '0, rdat, cycles);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_regs(input string name);
		logic [31:0] val;
		for (int i = 0; i < 32; i++) begin
			wb_read(bus_pkg::ADR_GPR_BASE + 8'(4 * i), val);
			check_value($sformatf("%s r%0d", name, i), model_regs[i], val);
		end
	endtask

	task automatic compare_counters(input string name);
		logic [31:0] val;
		wb_read(bus_pkg::ADR_RETIRED, val);
		check_value({name, " retired"}, model_retired, val);
		wb_read(bus_pkg::ADR_SPLITS, val);
		check_value({name, " splits"}, model_splits, val);
	endtask

	task automatic issue_pair(input logic [31:0] a, input logic [31:0] b);
		wb_write(bus_pkg::ADR_INSTR_A, a);
		wb_write(bus_pkg::ADR_INSTR_B, b);
		apply_pair(a, b);
	endtask

	task automatic after_reset();
		logic [31:0] val;
		wb_read(bus_pkg::ADR_STATUS, val);
		check_value("after_reset status", 32'd0, val);
		compare_counters("after_reset");
		compare_regs("after_reset");
	endtask

	task automatic alu_operations();
		logic [31:0] r [12];
		for (int i = 0; i < 12; i++)
			r[i] = next_rand();
		for (int k = 1; k < 9; k += 2) begin
			issue_pair(encode_i(isa_pkg::OP_ADDI, k, 0, r[k]),
				encode_i(isa_pkg::OP_ADDI, k + 1, 0, r[k + 1]));
		end
		issue_pair(encode_r(isa_pkg::OP_ADD, 9, 1, 2), encode_r(isa_pkg::OP_SUB, 10, 3, 4));
		issue_pair(encode_r(isa_pkg::OP_AND, 11, 5, 6), encode_r(isa_pkg::OP_OR, 12, 7, 8));
		issue_pair(encode_r(isa_pkg::OP_XOR, 13, 1, 8), encode_r(isa_pkg::OP_SLL, 14, 2, 3));
		issue_pair(encode_r(isa_pkg::OP_SRL, 15, 4, 5), encode_i(isa_pkg::OP_ORI, 16, 6, r[9]));
		issue_pair(encode_i(isa_pkg::OP_ANDI, 17, 7, r[10]),
			encode_i(isa_pkg::OP_XORI, 18, 8, r[11]));
		compare_regs("alu_operations");
	endtask

	task automatic dependent_pairs();
		logic [31:0] splits_before;
		logic [31:0] splits_after;
		logic [31:0] status;
		splits_before = model_splits;
		issue_pair(encode_r(isa_pkg::OP_ADD, 19, 1, 2), encode_r(isa_pkg::OP_SUB, 20, 19, 3));
		wb_read(bus_pkg::ADR_STATUS, status); // Pair still in flight.
		check_value("dependent_pairs busy", 32'd1, status);
		wb_read(bus_pkg::ADR_SPLITS, splits_after);
		check_value("dependent_pairs split", splits_before + 32'd1, splits_after);
		splits_before = splits_before + 32'd1;
		issue_pair(encode_r(isa_pkg::OP_XOR, 21, 4, 5), encode_r(isa_pkg::OP_ADD, 22, 6, 7));
		wb_read(bus_pkg::ADR_SPLITS, splits_after);
		check_value("dependent_pairs no split", splits_before, splits_after);
		compare_regs("dependent_pairs");
		compare_counters("dependent_pairs");
	endtask

	task automatic same_rd_priority();
		logic [31:0] imm_a;
		logic [31:0] imm_b;
		imm_a = next_rand();
		imm_b = next_rand();
		issue_pair(encode_i(isa_pkg::OP_ADDI, 23, 0, imm_a),
			encode_i(isa_pkg::OP_ADDI, 23, 0, imm_b));
		issue_pair(encode_r(isa_pkg::OP_ADD, 24, 1, 2), encode_r(isa_pkg::OP_SUB, 24, 3, 4));
		compare_regs("same_rd_priority");
	endtask

	task automatic register_zero();
		logic [31:0] val;
		val = next_rand();
		issue_pair(encode_i(isa_pkg::OP_ADDI, 0, 1, val), encode_r(isa_pkg::OP_ADD, 25, 0, 1));
		issue_pair(encode_r(isa_pkg::OP_ADD, 0, 1, 2), encode_r(isa_pkg::OP_OR, 0, 3, 4));
		wb_read(bus_pkg::ADR_GPR_BASE, val);
		check_value("register_zero r0", 32'd0, val);
		compare_regs("register_zero");
	endtask

	task automatic back_pressure();
		logic [31:0] a1;
		logic [31:0] b1;
		logic [31:0] b2;
		logic [31:0] unused;
		int cycles;
		a1 = encode_r(isa_pkg::OP_ADD, 26, 1, 2);
		b1 = encode_r(isa_pkg::OP_SLL, 27, 26, 3); // Split pair keeps busy high longer.
		b2 = encode_r(isa_pkg::OP_SUB, 28, 8, 7);
		wb_write(bus_pkg::ADR_INSTR_A, a1);
		wb_write(bus_pkg::ADR_INSTR_B, b1);
		bus_transfer(1'b1, bus_pkg::ADR_INSTR_B, b2, unused, cycles);
		apply_pair(a1, b1);
		apply_pair(a1, b2);
		assert (cycles > 1) else begin
			errors++;
			$display("back_pressure: second pair write was acked while the cluster was busy");
		end
		compare_regs("back_pressure");
		compare_counters("back_pressure");
	endtask

	initial begin
		req = '0;
		rst = 1'b1;
		lcg_state = 32'h4a4d;
		errors = 0;
		timeouts = 0;
		model_retired = 0;
		model_splits = 0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		after_reset();
		alu_operations();
		dependent_pairs();
		same_rd_priority();
		register_zero();
		back_pressure();
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
